/* Makefile */
# Verilator build and run of the cache testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cache: cache.f $(wildcard *.sv *.svh)
	verilator --binary -j 0 --top-module tb_cache -f cache.f -o Vtb_cache

run: obj_dir/Vtb_cache
	./obj_dir/Vtb_cache | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module cache_top -f cache.f

clean:
	rm -rf obj_dir sim.log

/* cache.f */
+incdir+.
cache_geom_pkg.sv
cache_bus_pkg.sv
way_port_if.sv
way_ram.sv
line_meta_store.sv
cache_ctrl.sv
cache_top.sv
tb_sdram_model.sv
tb_cache.sv

/* cache_bus_pkg.sv */
`include "cache_settings.svh"

package cache_bus_pkg;

    // device side carries bytes
    typedef logic [7:0] byte_t;

    // sdram and data ways carry 16-bit words
    typedef logic [15:0] word_t;

    // bit 0 enables the low byte, bit 1 the high byte
    typedef logic [1:0] byte_en_t;

    // word address on the sdram port
    typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;

endpackage

/* cache_ctrl.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_ctrl import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset_n,

    // device port
    input  dev_addr_t   address,
    input  byte_t       data_write,
    input  logic        read_req,
    input  logic        write_req,
    output logic        read_ack,
    output logic        write_ack,
    output byte_t       data_read,

    // sdram port
    output sdram_addr_t sdram_address,
    output word_t       sdram_data_write,
    input  word_t       sdram_data_read,
    output logic        sdram_read_req,
    output logic        sdram_write_req,
    input  logic        sdram_read_ack,
    input  logic        sdram_write_ack,

    // metadata store
    output set_index_t  lookup_index,
    output line_tag_t   lookup_tag,
    output logic        touch,
    output way_sel_t    touch_way,
    output logic        mark_dirty,
    output logic        fill_done,
    output way_sel_t    fill_way,
    output logic        clean_done,
    input  logic        hit,
    input  way_sel_t    hit_way,
    input  way_sel_t    victim_way,
    input  logic        victim_dirty,
    input  line_tag_t   victim_tag,

    way_port_if.controller way
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB_WAIT,
        S_WB_WRITE,
        S_FILL_REQ,
        S_FILL,
        S_FILL_END,
        S_DONE
    } state_t;

    state_t    state;
    dev_addr_t req_addr;
    byte_t     req_data;
    logic      req_write;
    way_sel_t  cur_way;
    word_sel_t word_cnt;
    word_t     cur_q;
    logic      last_word;

    // ~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~

    assign cur_q     = (cur_way == way_sel_t'(0)) ? way.q0 : way.q1;
    assign last_word = (word_cnt == word_sel_t'(`LINE_WORDS - 1));

    // even byte addresses live in the high half
    assign data_read = req_addr.byte_sel ? cur_q[7:0] : cur_q[15:8];

    // write-back word comes straight off the victim way
    assign sdram_data_write = cur_q;

    assign lookup_index = req_addr.index;
    assign lookup_tag   = req_addr.tag;
    assign touch        = (state == S_LOOKUP) && hit;
    assign touch_way    = hit_way;
    assign mark_dirty   = touch && req_write;
    assign fill_way     = cur_way;
    assign fill_done    = (state == S_FILL) && last_word;
    assign clean_done   = (state == S_WB_WRITE) && sdram_write_ack && last_word;

    // ~~~~~~~~~~~~~~~~~~~~
    // request FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= S_IDLE;
            read_ack        <= 1'b0;
            write_ack       <= 1'b0;
            sdram_read_req  <= 1'b0;
            sdram_write_req <= 1'b0;
            way.wr_en0      <= 1'b0;
            way.wr_en1      <= 1'b0;
            word_cnt        <= '0;
        end else begin
            // pulses
            read_ack   <= 1'b0;
            write_ack  <= 1'b0;
            way.wr_en0 <= 1'b0;
            way.wr_en1 <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (read_req || write_req) begin
                        req_addr  <= address;
                        req_data  <= data_write;
                        req_write <= !read_req;
                        // start the way read now so a hit needs no extra cycle
                        way.addr  <= {address.index, address.word};
                        state     <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        cur_way   <= hit_way;
                        read_ack  <= !req_write;
                        write_ack <= req_write;
                        state     <= S_DONE;
                    end else begin
                        cur_way  <= victim_way;
                        word_cnt <= '0;
                        way.addr <= {req_addr.index, word_sel_t'(0)};
                        if (victim_dirty) begin
                            sdram_address <= sdram_addr_t'({victim_tag, req_addr.index,
                                                            word_sel_t'(0)});
                            state         <= S_WB_WAIT;
                        end else begin
                            sdram_address  <= sdram_addr_t'({req_addr.tag, req_addr.index,
                                                             word_sel_t'(0)});
                            sdram_read_req <= 1'b1;
                            state          <= S_FILL_REQ;
                        end
                    end
                end
                S_WB_WAIT: begin
                    // way output catches up with the new address
                    sdram_write_req <= 1'b1;
                    state           <= S_WB_WRITE;
                end
                S_WB_WRITE: begin
                    if (sdram_write_ack) begin
                        sdram_write_req <= 1'b0;
                        word_cnt        <= word_cnt + 1'b1;
                        if (last_word) begin
                            sdram_address  <= sdram_addr_t'({req_addr.tag, req_addr.index,
                                                             word_sel_t'(0)});
                            sdram_read_req <= 1'b1;
                            state          <= S_FILL_REQ;
                        end else begin
                            sdram_address <= sdram_address + 1'b1;
                            way.addr      <= way.addr + 1'b1;
                            state         <= S_WB_WAIT;
                        end
                    end
                end
                S_FILL_REQ: begin
                    if (sdram_read_ack) begin
                        sdram_read_req <= 1'b0;
                        state          <= S_FILL;
                    end
                end
                S_FILL: begin
                    // one word per cycle, no stalls once the burst starts
                    way.addr    <= {req_addr.index, word_cnt};
                    way.wdata   <= sdram_data_read;
                    way.byte_en <= 2'b11;
                    way.wr_en0  <= (cur_way == way_sel_t'(0));
                    way.wr_en1  <= (cur_way == way_sel_t'(1));
                    word_cnt    <= word_cnt + 1'b1;
                    if (last_word) begin
                        state <= S_FILL_END;
                    end
                end
                S_FILL_END: begin
                    // last fill word lands this cycle, then retry as a hit
                    way.addr <= {req_addr.index, req_addr.word};
                    state    <= S_LOOKUP;
                end
                S_DONE: begin
                    if (req_write) begin
                        way.wdata   <= {req_data, req_data};
                        way.byte_en <= req_addr.byte_sel ? 2'b01 : 2'b10;
                        way.wr_en0  <= (cur_way == way_sel_t'(0));
                        way.wr_en1  <= (cur_way == way_sel_t'(1));
                    end
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* cache_geom_pkg.sv */
`include "cache_settings.svh"

package cache_geom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // address fields
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [`SET_IDX_W-1:0]  set_index_t;
    typedef logic [`TAG_W-1:0]      line_tag_t;
    typedef logic [`WORD_SEL_W-1:0] word_sel_t;

    // index in the upper bits, word within the line below
    typedef logic [`SET_IDX_W+`WORD_SEL_W-1:0] way_addr_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_sel_t;

    // byte address as seen on the device port
    // byte_sel 0 is the high half of the word, 1 the low half
    typedef struct packed {
        line_tag_t  tag;
        set_index_t index;
        word_sel_t  word;
        logic       byte_sel;
    } dev_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // line metadata
    // ~~~~~~~~~~~~~~~~~~~~

    // one entry per way per set
    typedef struct packed {
        line_tag_t tag;
        logic      valid;
        logic      dirty;
    } line_meta_t;

endpackage

/* cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// cache geometry
// ~~~~~~~~~~~~~~~~~~~~

`define CACHE_SETS      16
`define CACHE_WAYS      2
`define LINE_WORDS      8

// one way holds every set's line
`define WAY_DEPTH       128

// ~~~~~~~~~~~~~~~~~~~~
// address widths
// ~~~~~~~~~~~~~~~~~~~~

`define DEV_ADDR_W      17
`define SDRAM_ADDR_W    24
`define WORD_SEL_W      $clog2(`LINE_WORDS)
`define SET_IDX_W       $clog2(`CACHE_SETS)

// what is left of the byte address above index, word and byte select
`define TAG_W           (`DEV_ADDR_W - `SET_IDX_W - `WORD_SEL_W - 1)

`endif

/* cache_top.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_top import cache_geom_pkg::*, cache_bus_pkg::*; (
    input  logic                   sys_clk,
    input  logic                   reset_n,

    // device port
    input  byte_t                  data_write,
    output byte_t                  data_read,
    input  logic [`DEV_ADDR_W-1:0] address,
    input  logic                   read_req,
    input  logic                   write_req,
    output logic                   read_ack,
    output logic                   write_ack,

    // sdram port
    output sdram_addr_t            sdram_address,
    output word_t                  sdram_data_write,
    input  word_t                  sdram_data_read,
    output logic                   sdram_read_req,
    output logic                   sdram_write_req,
    input  logic                   sdram_read_ack,
    input  logic                   sdram_write_ack
);

    set_index_t lookup_index;
    line_tag_t  lookup_tag;
    logic       touch;
    way_sel_t   touch_way;
    logic       mark_dirty;
    logic       fill_done;
    way_sel_t   fill_way;
    logic       clean_done;
    logic       hit;
    way_sel_t   hit_way;
    way_sel_t   victim_way;
    logic       victim_dirty;
    line_tag_t  victim_tag;

    way_port_if way_bus ();

    cache_ctrl u_ctrl (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .address          (dev_addr_t'(address)),
        .data_write       (data_write),
        .read_req         (read_req),
        .write_req        (write_req),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .data_read        (data_read),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack),
        .lookup_index     (lookup_index),
        .lookup_tag       (lookup_tag),
        .touch            (touch),
        .touch_way        (touch_way),
        .mark_dirty       (mark_dirty),
        .fill_done        (fill_done),
        .fill_way         (fill_way),
        .clean_done       (clean_done),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_tag       (victim_tag),
        .way              (way_bus.controller)
    );

    line_meta_store u_meta (
        .sys_clk      (sys_clk),
        .reset_n      (reset_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .touch        (touch),
        .touch_way    (touch_way),
        .mark_dirty   (mark_dirty),
        .fill_done    (fill_done),
        .fill_way     (fill_way),
        .clean_done   (clean_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // the two data ways
    way_ram #(.way_id(way_sel_t'(0))) u_way0 (
        .sys_clk (sys_clk),
        .ram     (way_bus.ram)
    );

    way_ram #(.way_id(way_sel_t'(1))) u_way1 (
        .sys_clk (sys_clk),
        .ram     (way_bus.ram)
    );

endmodule

/* line_meta_store.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module line_meta_store import cache_geom_pkg::*; (
    input  logic       sys_clk,
    input  logic       reset_n,

    input  set_index_t lookup_index,
    input  line_tag_t  lookup_tag,
    input  logic       touch,
    input  way_sel_t   touch_way,
    input  logic       mark_dirty,
    input  logic       fill_done,
    input  way_sel_t   fill_way,
    input  logic       clean_done,

    output logic       hit,
    output way_sel_t   hit_way,
    output way_sel_t   victim_way,
    output logic       victim_dirty,
    output line_tag_t  victim_tag
);

    line_meta_t meta [`CACHE_WAYS][`CACHE_SETS];

    // least recently used way of each set
    way_sel_t   lru  [`CACHE_SETS];

    // ~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~

    // both tags compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (meta[w][lookup_index].valid && meta[w][lookup_index].tag == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_sel_t'(w);
            end
        end
    end

    // empty ways first, then lru
    always_comb begin
        if (!meta[0][lookup_index].valid) begin
            victim_way = way_sel_t'(0);
        end else if (!meta[1][lookup_index].valid) begin
            victim_way = way_sel_t'(1);
        end else begin
            victim_way = lru[lookup_index];
        end
    end

    assign victim_dirty = meta[victim_way][lookup_index].dirty;
    assign victim_tag   = meta[victim_way][lookup_index].tag;

    // ~~~~~~~~~~~~~~~~~~~~
    // updates
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            meta <= '{default: '0};
            lru  <= '{default: '0};
        end else begin
            if (touch) begin
                lru[lookup_index] <= ~touch_way;
            end
            if (mark_dirty) begin
                meta[touch_way][lookup_index].dirty <= 1'b1;
            end
            if (fill_done) begin
                meta[fill_way][lookup_index] <= '{tag: lookup_tag, valid: 1'b1, dirty: 1'b0};
            end
            if (clean_done) begin
                meta[victim_way][lookup_index].dirty <= 1'b0;
            end
        end
    end

endmodule

/* tb_cache.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module tb_cache import cache_bus_pkg::*; ();

    typedef enum logic [1:0] {
        dont_care,
        exp_hit,
        exp_miss
    } lookup_t;

    typedef struct packed {
        logic                   write;
        logic [`DEV_ADDR_W-1:0] addr;
        byte_t                  data;
        lookup_t                lookup;
    } row_t;

    logic                   sys_clk = 1'b0;
    logic                   reset_n;
    byte_t                  data_write;
    byte_t                  data_read;
    logic [`DEV_ADDR_W-1:0] address;
    logic                   read_req;
    logic                   write_req;
    logic                   read_ack;
    logic                   write_ack;
    sdram_addr_t            sdram_address;
    word_t                  sdram_data_write;
    word_t                  sdram_data_read;
    logic                   sdram_read_req;
    logic                   sdram_write_req;
    logic                   sdram_read_ack;
    logic                   sdram_write_ack;

    // reference copy of memory, one entry per device byte address
    byte_t       ref_mem [2**`DEV_ADDR_W];
    row_t        table_q [$];
    int          test_first [1:6];
    logic        table_ready = 1'b0;
    logic [31:0] seed_word;
    int          requests = 0;
    int          ack_count = 0;
    int          test_errors;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          writes_before;

    always #5 sys_clk = ~sys_clk;

    cache_top DUT (
        .sys_clk          (sys_clk),
        .reset_n          (reset_n),
        .data_write       (data_write),
        .data_read        (data_read),
        .address          (address),
        .read_req         (read_req),
        .write_req        (write_req),
        .read_ack         (read_ack),
        .write_ack        (write_ack),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack)
    );

    tb_sdram_model sdram (
        .sys_clk          (sys_clk),
        .sdram_address    (sdram_address),
        .sdram_data_write (sdram_data_write),
        .sdram_data_read  (sdram_data_read),
        .sdram_read_req   (sdram_read_req),
        .sdram_write_req  (sdram_write_req),
        .sdram_read_ack   (sdram_read_ack),
        .sdram_write_ack  (sdram_write_ack)
    );

    // every ack pulse, whichever request it answers
    always @(negedge sys_clk) begin
        if (read_ack) begin
            ack_count = ack_count + 1;
        end
        if (write_ack) begin
            ack_count = ack_count + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // table building
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`DEV_ADDR_W-1:0] byte_addr(input logic [8:0] tag,
            input logic [3:0] index, input logic [2:0] word, input logic byte_sel);
        return {tag, index, word, byte_sel};
    endfunction

    function automatic sdram_addr_t line_base(input logic [8:0] tag, input logic [3:0] index);
        return {8'd0, tag, index, 3'd0};
    endfunction

    function automatic void add_row(input logic write, input logic [`DEV_ADDR_W-1:0] addr,
            input byte_t data, input lookup_t lookup);
        row_t row;
        row.write  = write;
        row.addr   = addr;
        row.data   = data;
        row.lookup = lookup;
        table_q.push_back(row);
    endfunction

    function automatic void build_table();
        logic [31:0] rnd;
        test_first[1] = table_q.size();
        add_row(1'b0, byte_addr(9'h012, 4'd1, 3'd3, 1'b0), 8'h00, exp_miss);
        add_row(1'b0, byte_addr(9'h012, 4'd1, 3'd5, 1'b1), 8'h00, exp_hit);
        test_first[2] = table_q.size();
        add_row(1'b1, byte_addr(9'h034, 4'd2, 3'd2, 1'b0), 8'ha5, exp_miss);
        add_row(1'b0, byte_addr(9'h034, 4'd2, 3'd2, 1'b1), 8'h00, exp_hit);
        add_row(1'b0, byte_addr(9'h034, 4'd2, 3'd2, 1'b0), 8'h00, exp_hit);
        add_row(1'b1, byte_addr(9'h034, 4'd2, 3'd2, 1'b1), 8'h3c, exp_hit);
        add_row(1'b0, byte_addr(9'h034, 4'd2, 3'd2, 1'b0), 8'h00, exp_hit);
        add_row(1'b0, byte_addr(9'h034, 4'd2, 3'd2, 1'b1), 8'h00, exp_hit);
        // tags A, B, then A again makes B the older line when C arrives
        test_first[3] = table_q.size();
        add_row(1'b0, byte_addr(9'h100, 4'd3, 3'd0, 1'b0), 8'h00, exp_miss);
        add_row(1'b0, byte_addr(9'h101, 4'd3, 3'd0, 1'b0), 8'h00, exp_miss);
        add_row(1'b0, byte_addr(9'h100, 4'd3, 3'd1, 1'b1), 8'h00, exp_hit);
        add_row(1'b0, byte_addr(9'h102, 4'd3, 3'd0, 1'b0), 8'h00, exp_miss);
        add_row(1'b0, byte_addr(9'h100, 4'd3, 3'd2, 1'b0), 8'h00, exp_hit);
        add_row(1'b0, byte_addr(9'h101, 4'd3, 3'd3, 1'b1), 8'h00, exp_miss);
        test_first[4] = table_q.size();
        add_row(1'b1, byte_addr(9'h0aa, 4'd4, 3'd6, 1'b1), 8'h5a, exp_miss);
        add_row(1'b0, byte_addr(9'h0bb, 4'd4, 3'd0, 1'b0), 8'h00, exp_miss);
        add_row(1'b0, byte_addr(9'h0cc, 4'd4, 3'd0, 1'b0), 8'h00, exp_miss);
        // eight lines compete for the four ways of sets 8 and 9
        test_first[5] = table_q.size();
        for (int i = 0; i < 40; i++) begin
            rnd = $urandom;
            add_row(rnd[0], byte_addr({7'h7c, rnd[2:1]}, {3'b100, rnd[3]}, rnd[6:4], rnd[7]),
                    rnd[15:8], dont_care);
        end
        test_first[6] = table_q.size();
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus and checks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic apply_row(input row_t row);
        int    reads_before;
        byte_t expected;
        reads_before = sdram.line_reads;
        expected     = ref_mem[row.addr];
        @(negedge sys_clk);
        address    = row.addr;
        data_write = row.data;
        read_req   = !row.write;
        write_req  = row.write;
        requests++;
        do begin
            @(negedge sys_clk);
        end while (!read_ack && !write_ack);
        if (row.write != write_ack || row.write == read_ack) begin
            $display("request at address 0x%05h got the wrong kind of ack", row.addr);
            test_errors++;
        end else if (!row.write && data_read !== expected) begin
            $display("ERROR data_read: got 0x%02h expected 0x%02h at address 0x%05h",
                     data_read, expected, row.addr);
            test_errors++;
        end
        read_req  = 1'b0;
        write_req = 1'b0;
        if (row.write) begin
            ref_mem[row.addr] = row.data;
        end
        if (row.lookup == exp_hit) begin
            check_count("line_reads", sdram.line_reads - reads_before, 0);
        end else if (row.lookup == exp_miss) begin
            check_count("line_reads", sdram.line_reads - reads_before, 1);
        end
    endtask

    task automatic run_rows(input int test_num);
        for (int i = test_first[test_num]; i < test_first[test_num + 1]; i++) begin
            apply_row(table_q[i]);
        end
    endtask

    // written-back words must match the reference, in address order
    task automatic check_written_line(input sdram_addr_t base, input int first_write);
        logic [15:0] word_addr;
        word_t       expected_word;
        for (int i = 0; i < 8; i++) begin
            word_addr     = base[15:0] + 16'(i);
            expected_word = {ref_mem[{word_addr, 1'b0}], ref_mem[{word_addr, 1'b1}]};
            if (sdram.write_log[3'(first_write + i)] !== base + sdram_addr_t'(i)) begin
                $display("ERROR sdram_address: got 0x%06h expected 0x%06h",
                         sdram.write_log[3'(first_write + i)], base + sdram_addr_t'(i));
                test_errors++;
            end
            if (sdram.mem[word_addr] !== expected_word) begin
                $display("ERROR sdram_data_write: got 0x%04h expected 0x%04h at 0x%06h",
                         sdram.mem[word_addr], expected_word, base + sdram_addr_t'(i));
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input int test_num, input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: PASS", test_num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
            tests_failed++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed_word  = $urandom(32'hc7046ac7);
        reset_n    = 1'b0;
        address    = '0;
        data_write = '0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        for (int w = 0; w < 65536; w++) begin
            seed_word               = $urandom;
            sdram.mem[16'(w)]       = seed_word[15:0];
            // even byte address is the high half of its word
            ref_mem[17'(2 * w)]     = seed_word[15:8];
            ref_mem[17'(2 * w + 1)] = seed_word[7:0];
        end
        build_table();
        table_ready = 1'b1;
        repeat (8) @(negedge sys_clk);
        reset_n = 1'b1;

        test_errors = 0;
        run_rows(1);
        finish_test(1, "read miss then hit");

        test_errors   = 0;
        writes_before = sdram.word_writes;
        run_rows(2);
        check_count("word_writes", sdram.word_writes - writes_before, 0);
        finish_test(2, "write hit then read");

        test_errors = 0;
        run_rows(3);
        finish_test(3, "lru replacement");

        test_errors   = 0;
        writes_before = sdram.word_writes;
        run_rows(4);
        check_count("word_writes", sdram.word_writes - writes_before, 8);
        check_written_line(line_base(9'h0aa, 4'd4), writes_before);
        finish_test(4, "dirty eviction");

        test_errors = 0;
        run_rows(5);
        // let the ack monitor see the last pulse
        @(negedge sys_clk);
        check_count("read_ack/write_ack count", ack_count, requests);
        finish_test(5, "random traffic");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // generous budget per table row
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 200 + 8) @(posedge sys_clk);
        $display("watchdog expired before every request was acknowledged");
        $display("Test failed");
        $finish;
    end

endmodule

/* tb_sdram_model.sv */
`timescale 1ns/100ps

module tb_sdram_model import cache_bus_pkg::*; (
    input  logic        sys_clk,
    input  sdram_addr_t sdram_address,
    input  word_t       sdram_data_write,
    output word_t       sdram_data_read,
    input  logic        sdram_read_req,
    input  logic        sdram_write_req,
    output logic        sdram_read_ack,
    output logic        sdram_write_ack
);

    // word storage, filled by the testbench before reset ends
    word_t       mem [65536];

    // last eight write addresses, indexed by write count
    sdram_addr_t write_log [8];
    int          line_reads;
    int          word_writes;

    // ~~~~~~~~~~~~~~~~~~~~
    // line reads
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic serve_reads();
        sdram_addr_t base;
        forever begin
            @(negedge sys_clk);
            if (sdram_read_req) begin
                repeat ($urandom_range(3, 0)) @(negedge sys_clk);
                base           = sdram_address;
                sdram_read_ack = 1'b1;
                line_reads++;
                // burst of eight words, one per cycle after the ack
                for (int i = 0; i < 8; i++) begin
                    @(negedge sys_clk);
                    sdram_read_ack  = 1'b0;
                    sdram_data_read = mem[base[15:0] + 16'(i)];
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // word writes
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic serve_writes();
        forever begin
            @(negedge sys_clk);
            if (sdram_write_req) begin
                repeat ($urandom_range(3, 0)) @(negedge sys_clk);
                mem[sdram_address[15:0]]    = sdram_data_write;
                write_log[3'(word_writes)] = sdram_address;
                word_writes++;
                sdram_write_ack = 1'b1;
                @(negedge sys_clk);
                sdram_write_ack = 1'b0;
            end
        end
    endtask

    initial begin
        sdram_data_read = '0;
        sdram_read_ack  = 1'b0;
        sdram_write_ack = 1'b0;
        line_reads      = 0;
        word_writes     = 0;
        fork
            serve_reads();
            serve_writes();
        join
    end

endmodule

/* way_port_if.sv */
`timescale 1ns/100ps

interface way_port_if import cache_geom_pkg::*, cache_bus_pkg::*; ();

    way_addr_t addr;
    word_t     wdata;
    byte_en_t  byte_en;

    // one write enable and one read word per way
    logic      wr_en0;
    logic      wr_en1;
    word_t     q0;
    word_t     q1;

    modport controller (
        output addr, wdata, byte_en, wr_en0, wr_en1,
        input  q0, q1
    );

    modport ram (
        input  addr, wdata, byte_en, wr_en0, wr_en1,
        output q0, q1
    );

endinterface

/* way_ram.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module way_ram import cache_geom_pkg::*, cache_bus_pkg::*; #(
    parameter way_sel_t way_id = '0
) (
    input  logic sys_clk,
    way_port_if.ram ram
);

    word_t mem [`WAY_DEPTH];
    word_t q_reg;
    logic  wr_en;

    // pick this way's enable off the shared bus
    assign wr_en = (way_id == way_sel_t'(0)) ? ram.wr_en0 : ram.wr_en1;

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk) begin
        if (wr_en && ram.byte_en[0]) begin
            mem[ram.addr][7:0] <= ram.wdata[7:0];
        end
        if (wr_en && ram.byte_en[1]) begin
            mem[ram.addr][15:8] <= ram.wdata[15:8];
        end
        // old word on a same-address write
        q_reg <= mem[ram.addr];
    end

    // each instance drives only its own read word
    if (way_id == way_sel_t'(0)) begin : g_q0
        assign ram.q0 = q_reg;
    end else begin : g_q1
        assign ram.q1 = q_reg;
    end

endmodule
